/* rtl/sdram_pkg.sv */
/*
 * Shared widths, device command encodings, FSM states and cycle timings
 * for the SDR SDRAM controller. Referenced by scoped names only
 */
package sdram_pkg;

  //////////////////////////////////////////////////////////////
  // Device geometry

  localparam int DATA_W = 16;
  localparam int DQM_W = 2;
  localparam int BANK_W = 2;
  localparam int ROW_W = 13;
  localparam int COL_W = 9;
  localparam int HOST_ADDR_W = BANK_W + ROW_W + COL_W;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [DQM_W-1:0] dqm_t;
  typedef logic [BANK_W-1:0] bank_t;
  // Row width is also the width of the device address bus
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [COL_W-1:0] col_t;
  // Bank on top, then row, then column
  typedef logic [HOST_ADDR_W-1:0] host_addr_t;

  // Address bit that selects auto-precharge or precharge-all
  localparam int PRECHARGE_BIT = 10;

  //////////////////////////////////////////////////////////////
  // Commands and states

  // Bit order nCS, nRAS, nCAS, nWE
  typedef enum logic [3:0] {
    CMD_NOP          = 4'b0111,
    CMD_ACTIVE       = 4'b0011,
    CMD_READ         = 4'b0101,
    CMD_WRITE        = 4'b0100,
    CMD_PRECHARGE    = 4'b0010,
    CMD_AUTO_REFRESH = 4'b0001,
    CMD_LOAD_MODE    = 4'b0000
  } cmd_e;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_IDLE,
    ST_WAIT,
    ST_WRITE,
    ST_READ,
    ST_READ_WAIT
  } seq_state_e;

  // Timings in clock cycles at 100 MHz
  localparam int T_RCD_CYCLES = 2;
  localparam int T_RP_CYCLES = 2;
  localparam int T_RFC_CYCLES = 7;
  // Write recovery plus the auto-precharge period
  localparam int T_WR_RP_CYCLES = 4;
  localparam int T_MRD_CYCLES = 2;

  // Mode register value
  // Single-word write, standard mode, sequential, burst length 1
  function automatic row_t mode_word(input int unsigned cas_latency);
    return row_t'({3'b000, 1'b1, 2'b00, 3'(cas_latency), 1'b0, 3'b000});
  endfunction

endpackage

/* rtl/sdram_req_if.sv */
/*
 * One latched host request, passed from the host port to the sequencer,
 * with the completion strobe and read word coming back
 */
`timescale 1ns/1ps

interface sdram_req_if;

  // Request held until done
  logic valid;
  logic we;
  sdram_pkg::host_addr_t addr;
  sdram_pkg::data_t wdata;
  sdram_pkg::dqm_t byte_en;

  // Completion, one cycle wide
  logic done;
  sdram_pkg::data_t rdata;

  modport port (
    output valid, we, addr, wdata, byte_en,
    input done, rdata
  );

  modport seq (
    input valid, we, addr, wdata, byte_en,
    output done, rdata
  );

endinterface

/* rtl/sdram_cmd_if.sv */
/*
 * Device command stream from the sequencer to the pin driver,
 * with the captured read word and its strobe coming back
 */
`timescale 1ns/1ps

interface sdram_cmd_if;

  // Command word and address, one cycle ahead of the pins
  sdram_pkg::cmd_e cmd;
  sdram_pkg::bank_t ba;
  sdram_pkg::row_t a;
  sdram_pkg::dqm_t dqm;
  sdram_pkg::data_t wdata;
  logic cke;

  // Read return from the capture register
  logic rd_valid;
  sdram_pkg::data_t rd_data;

  modport seq (
    output cmd, ba, a, dqm, wdata, cke,
    input rd_valid, rd_data
  );

  modport phy (
    input cmd, ba, a, dqm, wdata, cke,
    output rd_valid, rd_data
  );

endinterface

/* rtl/sdram_host_port.sv */
/*
 * Host side of the controller. Latches one request on a req pulse,
 * holds it for the sequencer and turns its completion into ready and rdata
 */
`timescale 1ns/1ps

module sdram_host_port (
  input  logic                   clk,
  input  logic                   reset,
  input  sdram_pkg::host_addr_t  addr,
  input  sdram_pkg::data_t       wdata,
  input  sdram_pkg::dqm_t        byte_en,
  input  logic                   we,
  input  logic                   req,
  input  logic                   init_done,
  output logic                   available,
  output logic                   ready,
  output sdram_pkg::data_t       rdata,
  sdram_req_if.port              rq
);

  logic accept;

  // A request is taken only while the port is free
  assign accept = req && available;

  // Free after init, with nothing latched and no ready going out
  assign available = init_done && !rq.valid && !ready;

  //////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (reset) begin
      rq.valid <= 1'b0;
      ready <= 1'b0;
    end else begin
      // Ready lags the sequencer completion by one cycle
      ready <= rq.done;
      if (accept) begin
        rq.valid <= 1'b1;
      end else if (rq.done) begin
        rq.valid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (accept) begin
      rq.we <= we;
      rq.addr <= addr;
      rq.wdata <= wdata;
      rq.byte_en <= byte_en;
    end
    // Read word stays put until the next read completes
    if (rq.done && !rq.we) begin
      rdata <= rq.rdata;
    end
  end

  // Host must wait for available before pulsing req
  req_when_available: assert property (
    @(posedge clk) disable iff (reset) req |-> available
  ) else $error("req pulsed while available is low");

endmodule

/* rtl/sdram_sequencer.sv */
/*
 * Command sequencer. Runs the power-up sequence, keeps the refresh timer
 * and walks each latched request through ACTIVE, READ or WRITE and recovery
 */
`timescale 1ns/1ps

module sdram_sequencer #(
  parameter int CAS_LATENCY = 2,
  parameter int INIT_WAIT_CYCLES = 20000,
  parameter int REFRESH_INTERVAL_CYCLES = 750
) (
  input  logic       clk,
  input  logic       reset,
  output logic       init_done,
  sdram_req_if.seq   rq,
  sdram_cmd_if.seq   cmd
);

  // Init milestones on one counter
  localparam int INIT_CKE = INIT_WAIT_CYCLES / 2;
  localparam int INIT_PRE = INIT_WAIT_CYCLES;
  localparam int INIT_REF1 = INIT_PRE + sdram_pkg::T_RP_CYCLES;
  localparam int INIT_REF2 = INIT_REF1 + sdram_pkg::T_RFC_CYCLES;
  localparam int INIT_LMR = INIT_REF2 + sdram_pkg::T_RFC_CYCLES;
  localparam int INIT_END = INIT_LMR + sdram_pkg::T_MRD_CYCLES;
  localparam int INIT_W = $clog2(INIT_END + 1);
  localparam int REF_W = $clog2(REFRESH_INTERVAL_CYCLES + 1);

  sdram_pkg::seq_state_e state;
  sdram_pkg::seq_state_e after_wait;
  logic [2:0] wait_cnt;
  // Set while waiting out write recovery, so the end of the wait completes the access
  logic wr_finish;
  logic [INIT_W-1:0] init_cnt;
  logic [REF_W-1:0] ref_cnt;
  logic ref_pending;
  logic ref_wrap;

  // Request fields
  sdram_pkg::bank_t req_bank;
  sdram_pkg::row_t req_row;
  sdram_pkg::row_t col_addr;

  assign req_bank = rq.addr[sdram_pkg::HOST_ADDR_W-1 -: sdram_pkg::BANK_W];
  assign req_row = rq.addr[sdram_pkg::COL_W +: sdram_pkg::ROW_W];

  // Column on the low bits, auto-precharge bit set
  always_comb begin
    col_addr = '0;
    col_addr[sdram_pkg::COL_W-1:0] = sdram_pkg::col_t'(rq.addr[sdram_pkg::COL_W-1:0]);
    col_addr[sdram_pkg::PRECHARGE_BIT] = 1'b1;
  end

  assign ref_wrap = (ref_cnt == REF_W'(REFRESH_INTERVAL_CYCLES - 1));

  // Completion for writes at the end of recovery, for reads with the captured word
  assign rq.done = (state == sdram_pkg::ST_WAIT && wait_cnt == '0 && wr_finish) ||
                   (state == sdram_pkg::ST_READ_WAIT && cmd.rd_valid);
  assign rq.rdata = cmd.rd_data;

  //////////////////////////////////////////////////////////////
  // Sequencer FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sdram_pkg::ST_INIT;
      after_wait <= sdram_pkg::ST_IDLE;
      wait_cnt <= '0;
      wr_finish <= 1'b0;
      init_cnt <= '0;
      init_done <= 1'b0;
      ref_cnt <= '0;
      ref_pending <= 1'b0;
      cmd.cmd <= sdram_pkg::CMD_NOP;
      cmd.cke <= 1'b0;
    end else begin
      // NOP between commands
      cmd.cmd <= sdram_pkg::CMD_NOP;

      // Refresh timer runs freely once the device is up
      if (init_done) begin
        if (ref_wrap) begin
          ref_cnt <= '0;
          ref_pending <= 1'b1;
        end else begin
          ref_cnt <= ref_cnt + 1'b1;
        end
      end

      case (state)
        sdram_pkg::ST_INIT: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == INIT_W'(INIT_CKE)) begin
            cmd.cke <= 1'b1;
          end else if (init_cnt == INIT_W'(INIT_PRE)) begin
            // Precharge all banks
            cmd.cmd <= sdram_pkg::CMD_PRECHARGE;
            cmd.a <= '0;
            cmd.a[sdram_pkg::PRECHARGE_BIT] <= 1'b1;
          end else if (init_cnt == INIT_W'(INIT_REF1) || init_cnt == INIT_W'(INIT_REF2)) begin
            cmd.cmd <= sdram_pkg::CMD_AUTO_REFRESH;
          end else if (init_cnt == INIT_W'(INIT_LMR)) begin
            cmd.cmd <= sdram_pkg::CMD_LOAD_MODE;
            cmd.ba <= '0;
            cmd.a <= sdram_pkg::mode_word(CAS_LATENCY);
          end else if (init_cnt == INIT_W'(INIT_END)) begin
            state <= sdram_pkg::ST_IDLE;
            init_done <= 1'b1;
          end
        end

        sdram_pkg::ST_IDLE: begin
          if (ref_pending) begin
            // Refresh first, a waiting request stays latched
            cmd.cmd <= sdram_pkg::CMD_AUTO_REFRESH;
            ref_pending <= ref_wrap;
            state <= sdram_pkg::ST_WAIT;
            after_wait <= sdram_pkg::ST_IDLE;
            wait_cnt <= 3'(sdram_pkg::T_RFC_CYCLES - 2);
          end else if (rq.valid) begin
            // Open the row
            cmd.cmd <= sdram_pkg::CMD_ACTIVE;
            cmd.ba <= req_bank;
            cmd.a <= req_row;
            state <= sdram_pkg::ST_WAIT;
            after_wait <= rq.we ? sdram_pkg::ST_WRITE : sdram_pkg::ST_READ;
            wait_cnt <= 3'(sdram_pkg::T_RCD_CYCLES - 2);
          end
        end

        sdram_pkg::ST_WAIT: begin
          if (wait_cnt == '0) begin
            state <= after_wait;
            wr_finish <= 1'b0;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end

        sdram_pkg::ST_WRITE: begin
          // Bank still set from ACTIVE
          cmd.cmd <= sdram_pkg::CMD_WRITE;
          cmd.a <= col_addr;
          cmd.dqm <= ~rq.byte_en;
          cmd.wdata <= rq.wdata;
          state <= sdram_pkg::ST_WAIT;
          after_wait <= sdram_pkg::ST_IDLE;
          wait_cnt <= 3'(sdram_pkg::T_WR_RP_CYCLES);
          wr_finish <= 1'b1;
        end

        sdram_pkg::ST_READ: begin
          cmd.cmd <= sdram_pkg::CMD_READ;
          cmd.a <= col_addr;
          // Both bytes on reads
          cmd.dqm <= '0;
          state <= sdram_pkg::ST_READ_WAIT;
        end

        sdram_pkg::ST_READ_WAIT: begin
          // Word arrives CAS latency plus two cycles after READ
          if (cmd.rd_valid) begin
            state <= sdram_pkg::ST_IDLE;
          end
        end

        default: state <= sdram_pkg::ST_IDLE;
      endcase
    end
  end

  // Column commands only land on a row opened tRCD earlier
  col_after_active: assert property (
    @(posedge clk) disable iff (reset)
    (cmd.cmd inside {sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE}) |->
      $past(cmd.cmd, sdram_pkg::T_RCD_CYCLES) == sdram_pkg::CMD_ACTIVE
  ) else $error("READ or WRITE without a preceding ACTIVE");

  done_one_cycle: assert property (
    @(posedge clk) disable iff (reset) rq.done |=> !rq.done
  ) else $error("done held for two cycles");

endmodule

/* rtl/sdram_phy.sv */
/*
 * Pin driver. Registers the command stream onto the device pins, drives DQ
 * during writes and captures the read word after the CAS latency
 */
`timescale 1ns/1ps

module sdram_phy #(
  parameter int CAS_LATENCY = 2
) (
  input  logic               clk,
  input  logic               reset,
  sdram_cmd_if.phy           cmd,
  inout  sdram_pkg::data_t   sdram_dq,
  output sdram_pkg::row_t    sdram_a,
  output sdram_pkg::bank_t   sdram_ba,
  output sdram_pkg::dqm_t    sdram_dqm,
  output logic               sdram_cs_n,
  output logic               sdram_ras_n,
  output logic               sdram_cas_n,
  output logic               sdram_we_n,
  output logic               sdram_cke,
  output logic               sdram_clk
);

  sdram_pkg::cmd_e cmd_q;
  sdram_pkg::data_t dq_out;
  logic dq_oe;
  // Read marker, bit k is high k cycles after READ is on the pins
  logic [CAS_LATENCY:0] rd_pipe;

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
  assign sdram_dq = dq_oe ? dq_out : 'z;
  // Device samples on the falling edge of clk
  assign sdram_clk = ~clk;

  //////////////////////////////////////////////////////////////
  // Pin registers

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= sdram_pkg::CMD_NOP;
      sdram_cke <= 1'b0;
      dq_oe <= 1'b0;
    end else begin
      cmd_q <= cmd.cmd;
      sdram_cke <= cmd.cke;
      // Drive DQ only alongside WRITE
      dq_oe <= (cmd.cmd == sdram_pkg::CMD_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    sdram_a <= cmd.a;
    sdram_ba <= cmd.ba;
    sdram_dqm <= cmd.dqm;
    dq_out <= cmd.wdata;
  end

  //////////////////////////////////////////////////////////////
  // Read capture

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pipe <= '0;
      cmd.rd_valid <= 1'b0;
    end else begin
      rd_pipe <= {rd_pipe[CAS_LATENCY-1:0], cmd.cmd == sdram_pkg::CMD_READ};
      cmd.rd_valid <= rd_pipe[CAS_LATENCY];
    end
  end

  // Word is on DQ in the last stage
  always_ff @(posedge clk) begin
    if (rd_pipe[CAS_LATENCY]) begin
      cmd.rd_data <= sdram_dq;
    end
  end

  // Bus turnaround, no write data while the device may drive DQ
  no_dq_contention: assert property (
    @(posedge clk) disable iff (reset) dq_oe |-> !(|rd_pipe)
  ) else $error("DQ driven while a READ is in flight");

endmodule

/* rtl/sdram_ctrl.sv */
/*
 * Single-port SDR SDRAM controller top level. Host request port on one
 * side, device pins on the other
 */
`timescale 1ns/1ps

module sdram_ctrl #(
  parameter int CAS_LATENCY = 2,
  parameter int INIT_WAIT_CYCLES = 20000,
  parameter int REFRESH_INTERVAL_CYCLES = 750
) (
  input  logic                   clk,
  input  logic                   reset,
  // Host port
  input  sdram_pkg::host_addr_t  addr,
  input  sdram_pkg::data_t       wdata,
  input  sdram_pkg::dqm_t        byte_en,
  input  logic                   we,
  input  logic                   req,
  output logic                   available,
  output logic                   ready,
  output sdram_pkg::data_t       rdata,
  output logic                   init_done,
  // Device pins
  inout  sdram_pkg::data_t       sdram_dq,
  output sdram_pkg::row_t        sdram_a,
  output sdram_pkg::bank_t       sdram_ba,
  output sdram_pkg::dqm_t        sdram_dqm,
  output logic                   sdram_cs_n,
  output logic                   sdram_ras_n,
  output logic                   sdram_cas_n,
  output logic                   sdram_we_n,
  output logic                   sdram_cke,
  output logic                   sdram_clk
);

  sdram_req_if req_bus ();
  sdram_cmd_if cmd_bus ();

  // Input side
  sdram_host_port i_host_port (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .wdata     (wdata),
    .byte_en   (byte_en),
    .we        (we),
    .req       (req),
    .init_done (init_done),
    .available (available),
    .ready     (ready),
    .rdata     (rdata),
    .rq        (req_bus.port)
  );

  // Processing part
  sdram_sequencer #(
    .CAS_LATENCY             (CAS_LATENCY),
    .INIT_WAIT_CYCLES        (INIT_WAIT_CYCLES),
    .REFRESH_INTERVAL_CYCLES (REFRESH_INTERVAL_CYCLES)
  ) i_sequencer (
    .clk       (clk),
    .reset     (reset),
    .init_done (init_done),
    .rq        (req_bus.seq),
    .cmd       (cmd_bus.seq)
  );

  // Output side
  sdram_phy #(
    .CAS_LATENCY (CAS_LATENCY)
  ) i_phy (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd_bus.phy),
    .sdram_dq    (sdram_dq),
    .sdram_a     (sdram_a),
    .sdram_ba    (sdram_ba),
    .sdram_dqm   (sdram_dqm),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_cke   (sdram_cke),
    .sdram_clk   (sdram_clk)
  );

endmodule

/* tb/sdram_model.sv */
/*
 * Behavioral SDR SDRAM for simulation. Sparse word storage, reads returned
 * after the programmed CAS latency, and checks on the command protocol
 */
`timescale 1ns/1ps

module sdram_model (
  input  logic                          sdram_clk,
  input  logic                          sdram_cke,
  input  logic                          sdram_cs_n,
  input  logic                          sdram_ras_n,
  input  logic                          sdram_cas_n,
  input  logic                          sdram_we_n,
  input  sdram_pkg::bank_t              sdram_ba,
  input  sdram_pkg::row_t               sdram_a,
  input  sdram_pkg::dqm_t               sdram_dqm,
  inout  wire [sdram_pkg::DATA_W-1:0]   sdram_dq,
  output int                            violations,
  output int                            refresh_count,
  output logic                          init_seq_ok,
  output logic [2:0]                    mode_cas
);

  logic [3:0] cmd_bits;
  // Words keyed by bank, row and column
  sdram_pkg::data_t mem [int unsigned];
  sdram_pkg::row_t open_row [4];
  logic [3:0] bank_open;
  logic pre_all_seen;
  logic mode_set;
  logic active_seen;
  int edge_count;
  int last_active [4];
  int last_refresh;
  // Read delay line where stage k holds a word k edges after READ
  logic [3:0] rd_v;
  sdram_pkg::data_t rd_d [4];
  logic dq_oe;
  sdram_pkg::data_t dq_out;

  assign cmd_bits = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};
  assign sdram_dq = dq_oe ? dq_out : 'z;

  initial begin
    violations = 0;
    refresh_count = 0;
    init_seq_ok = 1'b0;
    mode_cas = 3'd0;
    bank_open = '0;
    pre_all_seen = 1'b0;
    mode_set = 1'b0;
    active_seen = 1'b0;
    edge_count = 0;
    last_refresh = -100;
    rd_v = '0;
    dq_oe = 1'b0;
  end

  // Fill for a word never written mixes in every address bit
  function automatic sdram_pkg::data_t fill_word(input int unsigned key);
    return key[15:0] ^ {8'ha5, key[23:16]};
  endfunction

  task automatic flag_violation(input string what);
    violations++;
    $display("Protocol violation at %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////////////////
  // Device clock edge

  always @(posedge sdram_clk) begin : device
    int unsigned key;
    sdram_pkg::data_t word;
    int cl;
    int i;
    edge_count++;
    cl = (mode_cas == 3'd3) ? 3 : 2;
    // Read word is driven for one edge starting CAS latency edges after READ
    dq_oe <= rd_v[cl-1];
    dq_out <= rd_d[cl-1];
    rd_v = {rd_v[2:0], 1'b0};
    for (i = 3; i > 0; i--) begin
      rd_d[i] = rd_d[i-1];
    end

    if (sdram_cke !== 1'b1) begin
      if (!$isunknown(cmd_bits) && cmd_bits != sdram_pkg::CMD_NOP) begin
        flag_violation("command issued while CKE is low");
      end
    end else begin
      case (cmd_bits)
        sdram_pkg::CMD_ACTIVE: begin
          if (!mode_set) begin
            flag_violation("ACTIVE before the mode register was loaded");
          end
          if (bank_open[sdram_ba]) begin
            flag_violation("ACTIVE to a bank that is already open");
          end
          if (edge_count - last_refresh < sdram_pkg::T_RFC_CYCLES) begin
            flag_violation("ACTIVE too soon after AUTO_REFRESH");
          end
          bank_open[sdram_ba] = 1'b1;
          open_row[sdram_ba] = sdram_a;
          last_active[sdram_ba] = edge_count;
          active_seen = 1'b1;
        end

        sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
          if (!bank_open[sdram_ba]) begin
            flag_violation("READ or WRITE to a closed bank");
          end else if (edge_count - last_active[sdram_ba] < sdram_pkg::T_RCD_CYCLES) begin
            flag_violation("READ or WRITE inside tRCD");
          end
          key = {sdram_ba, open_row[sdram_ba], sdram_a[sdram_pkg::COL_W-1:0]};
          word = mem.exists(key) ? mem[key] : fill_word(key);
          if (cmd_bits == sdram_pkg::CMD_WRITE) begin
            // DQM high masks a byte
            if (!sdram_dqm[0]) begin
              word[7:0] = sdram_dq[7:0];
            end
            if (!sdram_dqm[1]) begin
              word[15:8] = sdram_dq[15:8];
            end
            mem[key] = word;
          end else begin
            rd_v[0] = 1'b1;
            rd_d[0] = word;
          end
          if (sdram_a[sdram_pkg::PRECHARGE_BIT]) begin
            bank_open[sdram_ba] = 1'b0;
          end
        end

        sdram_pkg::CMD_PRECHARGE: begin
          if (sdram_a[sdram_pkg::PRECHARGE_BIT]) begin
            bank_open = '0;
            pre_all_seen = 1'b1;
          end else begin
            bank_open[sdram_ba] = 1'b0;
          end
        end

        sdram_pkg::CMD_AUTO_REFRESH: begin
          if (bank_open != '0) begin
            flag_violation("AUTO_REFRESH with a bank open");
          end
          if (edge_count - last_refresh < sdram_pkg::T_RFC_CYCLES) begin
            flag_violation("AUTO_REFRESH inside tRFC of the previous one");
          end
          refresh_count++;
          last_refresh = edge_count;
        end

        sdram_pkg::CMD_LOAD_MODE: begin
          if (bank_open != '0) begin
            flag_violation("LOAD_MODE with a bank open");
          end
          // Only single-word access is modeled
          if (sdram_a[2:0] != 3'b000 || !sdram_a[9]) begin
            flag_violation("mode word asks for bursts");
          end
          mode_cas = sdram_a[6:4];
          mode_set = 1'b1;
          init_seq_ok = pre_all_seen && refresh_count >= 2 && !active_seen;
        end

        default: begin
        end
      endcase
    end
  end

endmodule

/* tb/sdram_ctrl_tb.sv */
/*
 * Testbench for the SDRAM controller. Applies a table of host writes and
 * reads to the DUT on a device model and checks against a shadow memory
 */
`timescale 1ns/1ps

module sdram_ctrl_tb;

  localparam int CAS_LATENCY = 2;
  localparam int INIT_WAIT_CYCLES = 200;
  localparam int REFRESH_INTERVAL_CYCLES = 150;
  localparam int POOL_SIZE = 8;
  localparam int LONG_RUN = 28;
  localparam int NUM_ENTRIES = 2 + 5 + 2 * POOL_SIZE + LONG_RUN;
  // Generous per access, refresh included
  localparam int CYCLE_LIMIT = INIT_WAIT_CYCLES + 40 * NUM_ENTRIES + 500;

  typedef struct packed {
    logic [1:0] grp;
    logic is_write;
    sdram_pkg::host_addr_t addr;
    sdram_pkg::data_t wdata;
    sdram_pkg::dqm_t byte_en;
  } entry_t;

  logic clk;
  logic reset;
  sdram_pkg::host_addr_t addr;
  sdram_pkg::data_t wdata;
  sdram_pkg::dqm_t byte_en;
  logic we;
  logic req;
  logic available;
  logic ready;
  sdram_pkg::data_t rdata;
  logic init_done;

  // Device pins
  wire [sdram_pkg::DATA_W-1:0] sdram_dq;
  sdram_pkg::row_t sdram_a;
  sdram_pkg::bank_t sdram_ba;
  sdram_pkg::dqm_t sdram_dqm;
  logic sdram_cs_n;
  logic sdram_ras_n;
  logic sdram_cas_n;
  logic sdram_we_n;
  logic sdram_cke;
  logic sdram_clk;

  // Model status
  int violations;
  int refresh_count;
  logic init_seq_ok;
  logic [2:0] mode_cas;

  entry_t table_q[$];
  sdram_pkg::data_t shadow [int unsigned];
  sdram_pkg::host_addr_t pool [POOL_SIZE];
  string group_name [4];
  logic [31:0] rng_state;
  int check_count;
  int error_count;
  int cycle_count;

  sdram_ctrl #(
    .CAS_LATENCY             (CAS_LATENCY),
    .INIT_WAIT_CYCLES        (INIT_WAIT_CYCLES),
    .REFRESH_INTERVAL_CYCLES (REFRESH_INTERVAL_CYCLES)
  ) i_dut (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .byte_en     (byte_en),
    .we          (we),
    .req         (req),
    .available   (available),
    .ready       (ready),
    .rdata       (rdata),
    .init_done   (init_done),
    .sdram_dq    (sdram_dq),
    .sdram_a     (sdram_a),
    .sdram_ba    (sdram_ba),
    .sdram_dqm   (sdram_dqm),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_cke   (sdram_cke),
    .sdram_clk   (sdram_clk)
  );

  sdram_model i_model (
    .sdram_clk     (sdram_clk),
    .sdram_cke     (sdram_cke),
    .sdram_cs_n    (sdram_cs_n),
    .sdram_ras_n   (sdram_ras_n),
    .sdram_cas_n   (sdram_cas_n),
    .sdram_we_n    (sdram_we_n),
    .sdram_ba      (sdram_ba),
    .sdram_a       (sdram_a),
    .sdram_dqm     (sdram_dqm),
    .sdram_dq      (sdram_dq),
    .violations    (violations),
    .refresh_count (refresh_count),
    .init_seq_ok   (init_seq_ok),
    .mode_cas      (mode_cas)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic sdram_pkg::host_addr_t make_addr(input sdram_pkg::bank_t b,
                                                      input sdram_pkg::row_t r,
                                                      input sdram_pkg::col_t c);
    return {b, r, c};
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected,
                       input string msg);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("** Error at %0t: %s, got %h, expected %h", $time, msg, got, expected);
    end
  endtask

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic add_entry(input logic [1:0] grp, input logic is_write,
                           input sdram_pkg::host_addr_t a, input sdram_pkg::data_t d,
                           input sdram_pkg::dqm_t be);
    entry_t e;
    e.grp = grp;
    e.is_write = is_write;
    e.addr = a;
    e.wdata = d;
    e.byte_en = be;
    table_q.push_back(e);
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%-12s %s, %0d errors", name,
             (error_count == start_errors) ? "ok" : "FAILED", error_count - start_errors);
  endtask

  //////////////////////////////////////////////////////////////
  // Stimulus table

  task automatic build_table();
    sdram_pkg::host_addr_t a0;
    sdram_pkg::host_addr_t a1;
    int i;
    a0 = make_addr(2'd0, 13'h0005, 9'h010);
    a1 = make_addr(2'd1, 13'h0123, 9'h1ff);
    // Full write, then read back
    rng_state = xorshift32(rng_state);
    add_entry(2'd0, 1'b1, a0, rng_state[15:0], 2'b11);
    add_entry(2'd0, 1'b0, a0, '0, 2'b00);
    // Byte merges on top of a full word
    add_entry(2'd1, 1'b1, a1, 16'h1234, 2'b11);
    add_entry(2'd1, 1'b1, a1, 16'habcd, 2'b01);
    add_entry(2'd1, 1'b0, a1, '0, 2'b00);
    add_entry(2'd1, 1'b1, a1, 16'h5e77, 2'b10);
    add_entry(2'd1, 1'b0, a1, '0, 2'b00);
    // Two rows in each bank, read back in a shuffled order
    for (i = 0; i < POOL_SIZE; i++) begin
      pool[i] = make_addr(sdram_pkg::bank_t'(i % 4),
                          sdram_pkg::row_t'(13'h0040 + i * 13'h0101),
                          sdram_pkg::col_t'(i * 37));
      rng_state = xorshift32(rng_state);
      add_entry(2'd2, 1'b1, pool[i], rng_state[15:0], 2'b11);
    end
    for (i = 0; i < POOL_SIZE; i++) begin
      add_entry(2'd2, 1'b0, pool[(i * 3) % POOL_SIZE], '0, 2'b00);
    end
    // Random mix on words already written
    for (i = 0; i < LONG_RUN; i++) begin
      rng_state = xorshift32(rng_state);
      add_entry(2'd3, rng_state[0], pool[rng_state[6:4]], rng_state[31:16],
                rng_state[9:8]);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // One host access with handshake checks

  task automatic run_access(input entry_t e);
    sdram_pkg::data_t got;
    sdram_pkg::data_t expected;
    int b;
    while (available !== 1'b1) begin
      step_cycle();
    end
    req = 1'b1;
    we = e.is_write;
    addr = e.addr;
    wdata = e.wdata;
    byte_en = e.byte_en;
    step_cycle();
    req = 1'b0;
    // Busy from the cycle after req up to ready
    while (ready !== 1'b1) begin
      check(available, 1'b0, "available high while a request is pending");
      step_cycle();
    end
    check(available, 1'b0, "available high in the ready cycle");
    got = rdata;
    step_cycle();
    check(ready, 1'b0, "ready high for two cycles");
    check(available, 1'b1, "available low after ready");
    if (e.is_write) begin
      expected = shadow.exists(e.addr) ? shadow[e.addr] : 'x;
      for (b = 0; b < sdram_pkg::DQM_W; b++) begin
        if (e.byte_en[b]) begin
          expected[8*b +: 8] = e.wdata[8*b +: 8];
        end
      end
      shadow[e.addr] = expected;
    end else begin
      check(got, shadow[e.addr], $sformatf("read data at address %h", e.addr));
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int group_errors;
    int i;
    int init_cycle;
    int ref_at_init;
    int refreshes;
    int min_refreshes;
    reset = 1'b1;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    byte_en = '0;
    check_count = 0;
    error_count = 0;
    rng_state = 32'd31;
    group_name = '{"write_read", "byte_merge", "bank_spread", "long_run"};
    build_table();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Power-up sequence as seen by the device
    while (init_done !== 1'b1) begin
      step_cycle();
    end
    group_errors = error_count;
    check(init_seq_ok, 1'b1, "precharge-all, two refreshes, mode load before ACTIVE");
    check(mode_cas, CAS_LATENCY, "CAS field of the mode word");
    report_test("init", group_errors);
    init_cycle = cycle_count;
    ref_at_init = refresh_count;

    group_errors = error_count;
    for (i = 0; i < table_q.size(); i++) begin
      run_access(table_q[i]);
      if (i == table_q.size() - 1 || table_q[i+1].grp != table_q[i].grp) begin
        report_test(group_name[table_q[i].grp], group_errors);
        group_errors = error_count;
      end
    end

    // Refresh kept pace while requests were waiting
    refreshes = refresh_count - ref_at_init;
    min_refreshes = (cycle_count - init_cycle) / REFRESH_INTERVAL_CYCLES - 1;
    check(refreshes >= min_refreshes, 1'b1,
          $sformatf("%0d refreshes after init, at least %0d due", refreshes, min_refreshes));
    report_test("refresh", group_errors);

    $display("%0d checks, %0d errors, %0d protocol violations",
             check_count, error_count, violations);
    if (error_count == 0 && violations == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Checks failed");
    $finish;
  end

endmodule

/* sdram_ctrl.f */
rtl/sdram_pkg.sv
rtl/sdram_req_if.sv
rtl/sdram_cmd_if.sv
rtl/sdram_host_port.sv
rtl/sdram_sequencer.sv
rtl/sdram_phy.sv
rtl/sdram_ctrl.sv
tb/sdram_model.sv
tb/sdram_ctrl_tb.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - rtl/sdram_pkg.sv
  - rtl/sdram_req_if.sv
  - rtl/sdram_cmd_if.sv
  - rtl/sdram_host_port.sv
  - rtl/sdram_sequencer.sv
  - rtl/sdram_phy.sv
  - rtl/sdram_ctrl.sv
  - target: test
    files:
      - tb/sdram_model.sv
      - tb/sdram_ctrl_tb.sv
